//--- Makefile
TOP = command_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TB PASSED" sim.log

obj_dir/V$(TOP): compile.f hdl/*.sv hdl/*.svh bench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- bench/command_tb.sv
`timescale 1ns/1ps
`include "command_cfg.svh"

module command_tb;
	import command_pkg::*;

	typedef msg_byte_t byte_q_t[$];
	typedef arg_t arg_q_t[$];

	localparam int CYCLES_PER_CMD = 200;
	localparam int PIN_W = $clog2(`NGPIO);

	logic clk;
	logic rst;
	msg_byte_t msg_data;
	logic msg_ready;
	logic msg_rd_en;
	msg_byte_t send_ring_data;
	logic send_ring_wr_en;
	logic send_ring_full;
	rsp_len_t send_fifo_data;
	logic send_fifo_wr_en;
	systime_t systime;
	logic [`NGPIO-1:0] gpio;
	logic shutdown;

	// host stream, collected ring bytes and the expected responses in order.
	byte_q_t host_q;
	byte_q_t got_q;
	byte_q_t exp_bytes_q;
	int exp_len_q[$];
	logic is_time_q[$];
	systime_t time_lo_q[$];

	integer seed;
	logic stall_on;
	int cmds_sent;
	int rsp_expected;
	int rsp_seen;
	int errors;
	int tests;
	int test_errors;
	logic [`NGPIO-1:0] pins_model;
	logic shutdown_model;

	command_top dut_i (
		.clk(clk),
		.rst(rst),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en),
		.systime(systime),
		.gpio(gpio),
		.shutdown(shutdown)
	);

	always #2 clk = ~clk;

	function automatic arg_t decode_at(input byte_q_t b, input int start, output int used);
		arg_t v;
		int p;
		msg_byte_t c;
		v = '0;
		p = start;
		used = 0;
		if (start < b.size()) begin
			c = b[p];
			// bits 6 and 5 of the first byte give the sign.
			v = {{25{c[6] & c[5]}}, c[6:0]};
			while (c[7] && p + 1 < b.size()) begin
				p++;
				c = b[p];
				v = {v[24:0], c[6:0]};
			end
			used = p - start + 1;
		end
		return v;
	endfunction

	function automatic byte_q_t vlq_encode(input arg_t v);
		byte_q_t q;
		logic [34:0] x;
		int n;
		int i;
		int used;
		x = {{3{v[31]}}, v};
		for (n = 1; n <= 5; n++) begin
			q = {};
			for (i = n - 1; i >= 0; i--)
				q.push_back({i != 0, x[7 * i +: 7]});
			// shortest form that decodes back to the value.
			if (decode_at(q, 0, used) == v)
				return q;
		end
		return q;
	endfunction

	function automatic byte_q_t predict_rsp(input msg_byte_t id, input arg_q_t params);
		byte_q_t q;
		byte_q_t enc;
		q.push_back(id);
		foreach (params[k]) begin
			enc = vlq_encode(params[k]);
			foreach (enc[j])
				q.push_back(enc[j]);
		end
		return q;
	endfunction

	task automatic check_byte(input msg_byte_t got, input msg_byte_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_len(input rsp_len_t got, input rsp_len_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_arg(input arg_t got, input arg_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_pins();
		check_arg(arg_t'(gpio), arg_t'(pins_model), "gpio pins");
	endtask

	task automatic score_response();
		int n;
		int i;
		int pos;
		int used;
		msg_byte_t e;
		arg_t lo;
		arg_t hi;
		systime_t t;
		systime_t t_lo;
		check_len(send_fifo_data, rsp_len_t'(got_q.size()), "length against ring bytes");
		if (is_time_q.size() == 0) begin
			$display("a response of %0d bytes arrived with no command waiting for one",
				got_q.size());
			errors++;
		end else if (is_time_q.pop_front()) begin
			t_lo = time_lo_q.pop_front();
			check_byte(got_q.size() > 0 ? got_q[0] : 8'h00, `RSP_GET_TIME, "get time id");
			lo = decode_at(got_q, 1, used);
			pos = 1 + used;
			hi = decode_at(got_q, pos, used);
			check_len(rsp_len_t'(got_q.size()), rsp_len_t'(pos + used), "get time length");
			t = {hi, lo};
			if (t < t_lo || t > systime) begin
				$display("[ERROR] %0t: get time returned %0d, outside %0d to %0d",
					$time, t, t_lo, systime);
				errors++;
			end
		end else begin
			n = exp_len_q.pop_front();
			check_len(send_fifo_data, rsp_len_t'(n), "predicted length");
			for (i = 0; i < n; i++) begin
				e = exp_bytes_q.pop_front();
				if (i < got_q.size())
					check_byte(got_q[i], e, "response byte");
			end
		end
	endtask

	task automatic compare_responses();
		forever begin
			@(posedge clk);
			if (!rst) begin
				if (send_ring_wr_en) begin
					if (send_ring_full) begin
						$display("[ERROR] %0t: ring write while send_ring_full is high", $time);
						errors++;
					end
					got_q.push_back(send_ring_data);
				end
				if (send_fifo_wr_en) begin
					score_response();
					got_q = {};
					rsp_seen++;
				end
			end
		end
	endtask

	// the host drops a byte once msg_rd_en shows it was taken.
	task automatic drive_host();
		forever begin
			@(posedge clk);
			if (msg_rd_en && host_q.size() > 0)
				host_q.delete(0);
			msg_ready <= host_q.size() > 0;
			msg_data <= (host_q.size() > 0) ? host_q[0] : 8'h00;
		end
	endtask

	task automatic drive_stall();
		forever begin
			@(posedge clk);
			if (stall_on)
				send_ring_full <= ($random(seed) & 32'd1) != 32'd0;
			else
				send_ring_full <= 1'b0;
		end
	endtask

	task automatic advance_time();
		forever begin
			@(posedge clk);
			systime <= systime + 64'd1;
		end
	endtask

	task automatic watchdog();
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > CYCLES_PER_CMD * (cmds_sent + 1)) begin
				$display("timeout after %0d cycles, %0d of %0d responses seen",
					cycles, rsp_seen, rsp_expected);
				$display("TB FAILED");
				$finish;
			end
		end
	endtask

	task automatic send_cmd(input msg_byte_t id, input arg_q_t args);
		byte_q_t enc;
		@(negedge clk);
		host_q.push_back(id);
		foreach (args[k]) begin
			enc = vlq_encode(args[k]);
			foreach (enc[j])
				host_q.push_back(enc[j]);
		end
		cmds_sent++;
	endtask

	task automatic issue_version();
		arg_q_t none;
		arg_q_t p;
		byte_q_t exp;
		p.push_back(`CMD_VERSION);
		exp = predict_rsp(`RSP_GET_VERSION, p);
		foreach (exp[k])
			exp_bytes_q.push_back(exp[k]);
		exp_len_q.push_back(exp.size());
		is_time_q.push_back(1'b0);
		rsp_expected++;
		send_cmd({3'b000, `CMD_GET_VERSION}, none);
	endtask

	task automatic issue_time();
		arg_q_t none;
		is_time_q.push_back(1'b1);
		rsp_expected++;
		send_cmd({3'b000, `CMD_GET_TIME}, none);
		time_lo_q.push_back(systime);
	endtask

	task automatic send_unknown(input msg_byte_t id);
		arg_q_t none;
		send_cmd(id, none);
	endtask

	task automatic set_out(input arg_t ch, input arg_t val);
		arg_q_t a;
		a.push_back(ch);
		a.push_back(val);
		send_cmd({3'b000, `CMD_SET_DIGITAL_OUT}, a);
		if (ch < `NGPIO && !shutdown_model)
			pins_model[ch[PIN_W-1:0]] = val[0];
	endtask

	task automatic wait_responses();
		while (rsp_seen < rsp_expected)
			@(negedge clk);
	endtask

	// a get version behind a command proves the command has finished.
	task automatic set_pin_and_check(input arg_t ch, input arg_t val);
		set_out(ch, val);
		issue_version();
		wait_responses();
		check_pins();
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		msg_data = '0;
		msg_ready = 1'b0;
		send_ring_full = 1'b0;
		systime = 64'h0000_0123_f000_0000;
		seed = 32'hc35f;
		stall_on = 1'b0;
		cmds_sent = 0;
		rsp_expected = 0;
		rsp_seen = 0;
		errors = 0;
		tests = 0;
		test_errors = 0;
		pins_model = '0;
		shutdown_model = 1'b0;
		fork
			drive_host();
			drive_stall();
			advance_time();
			compare_responses();
			watchdog();
		join_none
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		issue_version();
		wait_responses();
		end_test("get version");

		issue_time();
		issue_time();
		wait_responses();
		end_test("get time");

		set_pin_and_check(32'd3, 32'h0001_2345);
		set_pin_and_check(32'd5, arg_t'(-32'sd12345679));
		set_pin_and_check(32'd3, arg_t'(-32'sd1000));
		set_pin_and_check(32'd0, 32'h7fff_ffff);
		// pin 0 is high here, so a wrapped channel 8 would show.
		set_pin_and_check(32'd8, 32'd0);
		set_pin_and_check(32'hffff_ffff, 32'd1);
		end_test("set digital out");

		send_unknown(8'd5);
		send_unknown(8'd31);
		send_unknown(8'h45);
		issue_version();
		wait_responses();
		check_pins();
		end_test("unknown ids");

		stall_on = 1'b1;
		for (i = 0; i < 4; i++) begin
			issue_version();
			issue_time();
		end
		set_out(32'd6, 32'd1);
		issue_version();
		wait_responses();
		check_pins();
		stall_on = 1'b0;
		end_test("ring stalls");

		send_unknown({3'b000, `CMD_SHUTDOWN});
		shutdown_model = 1'b1;
		pins_model = '0;
		issue_version();
		wait_responses();
		check_arg(arg_t'(shutdown), 32'd1, "shutdown flag");
		check_pins();
		set_pin_and_check(32'd1, 32'd1);
		end_test("shutdown");

		if (got_q.size() != 0) begin
			$display("%0d ring bytes were written without a length write", got_q.size());
			errors++;
		end
		$display("%0d tests, %0d responses, %0d errors", tests, rsp_seen, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+hdl
hdl/command_pkg.sv
hdl/vlq_arg_parser.sv
hdl/cmd_dispatcher.sv
hdl/vlq_rsp_encoder.sv
hdl/system_unit.sv
hdl/gpio_unit.sv
hdl/command_top.sv
bench/command_tb.sv

//--- hdl/cmd_dispatcher.sv
`timescale 1ns/1ps
`include "command_cfg.svh"

module cmd_dispatcher (
	input logic clk,
	input logic rst,
	input logic parsed,
	input command_pkg::cmd_desc_t desc,
	input command_pkg::cmd_id_t cmd,
	output logic release_cmd,
	output command_pkg::arg_idx_t arg_rd_idx,
	input command_pkg::arg_t arg_rd_data,
	output command_pkg::unit_cmd_t sys_cmd,
	output command_pkg::unit_cmd_t gpio_cmd,
	input command_pkg::unit_rsp_t sys_rsp,
	input command_pkg::unit_rsp_t gpio_rsp,
	output logic rsp_start,
	output command_pkg::msg_byte_t rsp_id,
	output command_pkg::arg_idx_t nparams,
	input command_pkg::arg_idx_t param_idx,
	output command_pkg::arg_t param_data,
	input logic rsp_finished
);
	import command_pkg::*;

	typedef enum logic [1:0] {
		D_IDLE,
		D_LOAD,
		D_RUN,
		D_RESPOND
	} disp_state_e;

	disp_state_e state;
	unit_e cur_unit;
	logic cur_has_rsp;
	cmd_id_t cur_cmd;
	arg_t cur_arg;
	logic sys_ready;
	logic gpio_ready;
	arg_t params [`MAX_ARGS];
	unit_rsp_t sel_rsp;

	assign sys_cmd = '{cmd: cur_cmd, arg: cur_arg, ready: sys_ready};
	assign gpio_cmd = '{cmd: cur_cmd, arg: cur_arg, ready: gpio_ready};
	assign param_data = params[param_idx];

	always_comb begin
		case (cur_unit)
			UNIT_SYSTEM: sel_rsp = sys_rsp;
			UNIT_GPIO: sel_rsp = gpio_rsp;
			default: sel_rsp = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= D_IDLE;
			release_cmd <= 1'b0;
			rsp_start <= 1'b0;
			sys_ready <= 1'b0;
			gpio_ready <= 1'b0;
		end else begin
			release_cmd <= 1'b0;
			rsp_start <= 1'b0;
			sys_ready <= 1'b0;
			gpio_ready <= 1'b0;
			case (state)
				D_IDLE: begin
					if (parsed) begin
						cur_unit <= desc.unit;
						cur_has_rsp <= desc.has_rsp;
						cur_cmd <= cmd;
						arg_rd_idx <= '0;
						// nothing handles unknown ids, drop them.
						if (desc.unit == UNIT_NONE)
							release_cmd <= 1'b1;
						else
							state <= D_LOAD;
					end
				end
				D_LOAD: begin
					cur_arg <= arg_rd_data;
					arg_rd_idx <= arg_rd_idx + 3'd1;
					nparams <= '0;
					sys_ready <= (cur_unit == UNIT_SYSTEM);
					gpio_ready <= (cur_unit == UNIT_GPIO);
					state <= D_RUN;
				end
				D_RUN: begin
					if (sel_rsp.arg_advance) begin
						cur_arg <= arg_rd_data;
						arg_rd_idx <= arg_rd_idx + 3'd1;
					end
					if (sel_rsp.param_write) begin
						params[nparams] <= sel_rsp.param_data;
						nparams <= nparams + 3'd1;
					end
					if (sel_rsp.done) begin
						rsp_id <= sel_rsp.param_data[7:0];
						if (cur_has_rsp) begin
							rsp_start <= 1'b1;
							state <= D_RESPOND;
						end else begin
							release_cmd <= 1'b1;
							state <= D_IDLE;
						end
					end
				end
				default: begin
					if (rsp_finished) begin
						release_cmd <= 1'b1;
						state <= D_IDLE;
					end
				end
			endcase
		end
	end

	// only one unit may own the shared argument store.
	assert property (@(posedge clk) disable iff (rst) !(sys_cmd.ready && gpio_cmd.ready));

endmodule

//--- hdl/command_cfg.svh
`ifndef COMMAND_CFG_SVH
`define COMMAND_CFG_SVH

// value returned by get version.
`define CMD_VERSION 32'h0001_0203

// argument store depth in words.
`define MAX_ARGS 8

// number of digital outputs.
`define NGPIO 8

// command ids.
`define CMD_GET_VERSION 5'd0
`define CMD_GET_TIME 5'd2
`define CMD_SET_DIGITAL_OUT 5'd15
`define CMD_SHUTDOWN 5'd19

// response ids.
`define RSP_GET_VERSION 8'd0
`define RSP_GET_TIME 8'd1

`endif

//--- hdl/command_pkg.sv
`include "command_cfg.svh"

package command_pkg;

	typedef logic [7:0] msg_byte_t;
	typedef logic [31:0] arg_t;
	typedef logic [2:0] arg_idx_t;
	typedef logic [4:0] cmd_id_t;
	typedef logic [63:0] systime_t;
	typedef logic [7:0] rsp_len_t;

	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_SYSTEM,
		UNIT_GPIO
	} unit_e;

	// one command table entry.
	typedef struct packed {
		unit_e unit;
		logic [3:0] nargs;
		logic has_rsp;
	} cmd_desc_t;

	// dispatcher to unit.
	typedef struct packed {
		cmd_id_t cmd;
		arg_t arg;
		logic ready;
	} unit_cmd_t;

	// the done pulse from a unit carries the response id in param_data.
	typedef struct packed {
		logic arg_advance;
		logic param_write;
		logic done;
		arg_t param_data;
	} unit_rsp_t;

	function automatic cmd_desc_t cmd_lookup(input cmd_id_t id);
		cmd_desc_t d;
		case (id)
			`CMD_GET_VERSION: d = '{unit: UNIT_SYSTEM, nargs: 4'd0, has_rsp: 1'b1};
			`CMD_GET_TIME: d = '{unit: UNIT_SYSTEM, nargs: 4'd0, has_rsp: 1'b1};
			`CMD_SHUTDOWN: d = '{unit: UNIT_SYSTEM, nargs: 4'd0, has_rsp: 1'b0};
			`CMD_SET_DIGITAL_OUT: d = '{unit: UNIT_GPIO, nargs: 4'd2, has_rsp: 1'b0};
			default: d = '{unit: UNIT_NONE, nargs: 4'd0, has_rsp: 1'b0};
		endcase
		return d;
	endfunction

endpackage

//--- hdl/command_top.sv
`timescale 1ns/1ps
`include "command_cfg.svh"

module command_top (
	input logic clk,
	input logic rst,
	input command_pkg::msg_byte_t msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	output command_pkg::msg_byte_t send_ring_data,
	output logic send_ring_wr_en,
	input logic send_ring_full,
	output command_pkg::rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en,
	input command_pkg::systime_t systime,
	output logic [`NGPIO-1:0] gpio,
	output logic shutdown
);
	import command_pkg::*;

	logic parsed;
	logic release_cmd;
	cmd_desc_t desc;
	cmd_id_t cmd;
	arg_idx_t arg_rd_idx;
	arg_t arg_rd_data;
	unit_cmd_t sys_cmd;
	unit_cmd_t gpio_cmd;
	unit_rsp_t sys_rsp;
	unit_rsp_t gpio_rsp;
	logic rsp_start;
	msg_byte_t rsp_id;
	arg_idx_t nparams;
	arg_idx_t param_idx;
	arg_t param_data;
	logic rsp_finished;

	vlq_arg_parser u_parser (
		.clk(clk),
		.rst(rst),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.release_cmd(release_cmd),
		.parsed(parsed),
		.desc(desc),
		.cmd(cmd),
		.arg_rd_idx(arg_rd_idx),
		.arg_rd_data(arg_rd_data)
	);

	cmd_dispatcher u_dispatcher (
		.clk(clk),
		.rst(rst),
		.parsed(parsed),
		.desc(desc),
		.cmd(cmd),
		.release_cmd(release_cmd),
		.arg_rd_idx(arg_rd_idx),
		.arg_rd_data(arg_rd_data),
		.sys_cmd(sys_cmd),
		.gpio_cmd(gpio_cmd),
		.sys_rsp(sys_rsp),
		.gpio_rsp(gpio_rsp),
		.rsp_start(rsp_start),
		.rsp_id(rsp_id),
		.nparams(nparams),
		.param_idx(param_idx),
		.param_data(param_data),
		.rsp_finished(rsp_finished)
	);

	vlq_rsp_encoder u_encoder (
		.clk(clk),
		.rst(rst),
		.rsp_start(rsp_start),
		.rsp_id(rsp_id),
		.nparams(nparams),
		.param_idx(param_idx),
		.param_data(param_data),
		.rsp_finished(rsp_finished),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en)
	);

	system_unit u_system (
		.clk(clk),
		.rst(rst),
		.unit_cmd(sys_cmd),
		.unit_rsp(sys_rsp),
		.systime(systime),
		.shutdown(shutdown)
	);

	gpio_unit u_gpio (
		.clk(clk),
		.rst(rst),
		.unit_cmd(gpio_cmd),
		.unit_rsp(gpio_rsp),
		.shutdown(shutdown),
		.gpio(gpio)
	);

endmodule

//--- hdl/gpio_unit.sv
`timescale 1ns/1ps
`include "command_cfg.svh"

module gpio_unit (
	input logic clk,
	input logic rst,
	input command_pkg::unit_cmd_t unit_cmd,
	output command_pkg::unit_rsp_t unit_rsp,
	input logic shutdown,
	output logic [`NGPIO-1:0] gpio
);
	import command_pkg::*;

	localparam int GPIO_IDX_W = $clog2(`NGPIO);

	logic [1:0] step;
	arg_t chan;
	logic adv;
	logic dn;

	assign unit_rsp = '{arg_advance: adv, param_write: 1'b0, done: dn, param_data: '0};

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= 2'd0;
			adv <= 1'b0;
			dn <= 1'b0;
			gpio <= '0;
		end else begin
			adv <= 1'b0;
			dn <= 1'b0;
			if (unit_cmd.ready) begin
				// channel comes with ready, ask for the value.
				chan <= unit_cmd.arg;
				adv <= 1'b1;
				step <= 2'd1;
			end else if (step == 2'd1) begin
				step <= 2'd2;
			end else if (step == 2'd2) begin
				step <= 2'd0;
				dn <= 1'b1;
				if (unit_cmd.cmd == `CMD_SET_DIGITAL_OUT && chan < 32'(`NGPIO) && !shutdown)
					gpio[chan[GPIO_IDX_W-1:0]] <= unit_cmd.arg[0];
			end
			if (shutdown)
				gpio <= '0;
		end
	end

endmodule

//--- hdl/system_unit.sv
`timescale 1ns/1ps
`include "command_cfg.svh"

module system_unit (
	input logic clk,
	input logic rst,
	input command_pkg::unit_cmd_t unit_cmd,
	output command_pkg::unit_rsp_t unit_rsp,
	input command_pkg::systime_t systime,
	output logic shutdown
);
	import command_pkg::*;

	logic busy;
	logic [1:0] step;
	cmd_id_t op;
	systime_t time_q;
	logic pw;
	logic dn;
	arg_t pd;

	assign unit_rsp = '{arg_advance: 1'b0, param_write: pw, done: dn, param_data: pd};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			step <= 2'd0;
			pw <= 1'b0;
			dn <= 1'b0;
			shutdown <= 1'b0;
		end else begin
			pw <= 1'b0;
			dn <= 1'b0;
			if (unit_cmd.ready) begin
				busy <= 1'b1;
				step <= 2'd0;
				op <= unit_cmd.cmd;
				time_q <= systime;
			end else if (busy) begin
				step <= step + 2'd1;
				case (op)
					`CMD_GET_VERSION: begin
						if (step == 2'd0) begin
							pw <= 1'b1;
							pd <= `CMD_VERSION;
						end else begin
							dn <= 1'b1;
							pd <= {24'd0, `RSP_GET_VERSION};
							busy <= 1'b0;
						end
					end
					`CMD_GET_TIME: begin
						// low word first.
						if (step == 2'd0) begin
							pw <= 1'b1;
							pd <= time_q[31:0];
						end else if (step == 2'd1) begin
							pw <= 1'b1;
							pd <= time_q[63:32];
						end else begin
							dn <= 1'b1;
							pd <= {24'd0, `RSP_GET_TIME};
							busy <= 1'b0;
						end
					end
					default: begin
						if (op == `CMD_SHUTDOWN)
							shutdown <= 1'b1;
						dn <= 1'b1;
						pd <= '0;
						busy <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- hdl/vlq_arg_parser.sv
`timescale 1ns/1ps
`include "command_cfg.svh"

module vlq_arg_parser (
	input logic clk,
	input logic rst,
	input command_pkg::msg_byte_t msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	input logic release_cmd,
	output logic parsed,
	output command_pkg::cmd_desc_t desc,
	output command_pkg::cmd_id_t cmd,
	input command_pkg::arg_idx_t arg_rd_idx,
	output command_pkg::arg_t arg_rd_data
);
	import command_pkg::*;

	typedef enum logic [2:0] {
		P_IDLE,
		P_ARG_START,
		P_ARG_CONT,
		P_ARG_END,
		P_PENDING
	} parse_state_e;

	parse_state_e state;
	arg_t args [`MAX_ARGS];
	arg_idx_t curr_arg;
	arg_t tmp_arg;
	cmd_desc_t id_desc;
	logic take;

	// ids above the 5-bit range are unknown.
	assign id_desc = (msg_data[7:5] == 3'b000) ? cmd_lookup(msg_data[4:0]) : '0;
	assign take = msg_ready && !msg_rd_en;
	assign arg_rd_data = args[arg_rd_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= P_IDLE;
			msg_rd_en <= 1'b0;
			parsed <= 1'b0;
		end else begin
			msg_rd_en <= 1'b0;
			parsed <= 1'b0;
			case (state)
				P_IDLE: begin
					if (take) begin
						msg_rd_en <= 1'b1;
						cmd <= msg_data[4:0];
						desc <= id_desc;
						curr_arg <= '0;
						if (id_desc.nargs == 4'd0) begin
							parsed <= 1'b1;
							state <= P_PENDING;
						end else begin
							state <= P_ARG_START;
						end
					end
				end
				P_ARG_START: begin
					if (take) begin
						msg_rd_en <= 1'b1;
						// bits 6 and 5 both set mark a negative value.
						tmp_arg <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
						state <= msg_data[7] ? P_ARG_CONT : P_ARG_END;
					end
				end
				P_ARG_CONT: begin
					if (take) begin
						msg_rd_en <= 1'b1;
						tmp_arg <= {tmp_arg[24:0], msg_data[6:0]};
						if (!msg_data[7])
							state <= P_ARG_END;
					end
				end
				P_ARG_END: begin
					args[curr_arg] <= tmp_arg;
					curr_arg <= curr_arg + 3'd1;
					if ({1'b0, curr_arg} + 4'd1 == desc.nargs) begin
						parsed <= 1'b1;
						state <= P_PENDING;
					end else begin
						state <= P_ARG_START;
					end
				end
				default: begin
					if (release_cmd)
						state <= P_IDLE;
				end
			endcase
		end
	end

	// the host only presents a byte while msg_ready is up.
	assert property (@(posedge clk) disable iff (rst) msg_rd_en |-> msg_ready);

endmodule

//--- hdl/vlq_rsp_encoder.sv
`timescale 1ns/1ps

module vlq_rsp_encoder (
	input logic clk,
	input logic rst,
	input logic rsp_start,
	input command_pkg::msg_byte_t rsp_id,
	input command_pkg::arg_idx_t nparams,
	output command_pkg::arg_idx_t param_idx,
	input command_pkg::arg_t param_data,
	output logic rsp_finished,
	output command_pkg::msg_byte_t send_ring_data,
	output logic send_ring_wr_en,
	input logic send_ring_full,
	output command_pkg::rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en
);
	import command_pkg::*;

	typedef enum logic [1:0] {
		E_IDLE,
		E_ID,
		E_SIZE,
		E_EMIT
	} enc_state_e;

	enc_state_e state;
	msg_byte_t id_q;
	arg_idx_t np_q;
	rsp_len_t len;
	logic [34:0] sh;
	logic [2:0] cnt;
	logic [34:0] p_ext;
	logic [2:0] size;
	logic [5:0] shamt;
	logic byte_valid;
	logic last_param;

	// fewest 7-bit groups that sign-extend back to the value.
	always_comb begin
		p_ext = {{3{param_data[31]}}, param_data};
		if ($signed(param_data) >= -32'sd32 && $signed(param_data) < 32'sd96) begin
			size = 3'd1;
			shamt = 6'd28;
		end else if ($signed(param_data) >= -32'sd4096 && $signed(param_data) < 32'sd12288) begin
			size = 3'd2;
			shamt = 6'd21;
		end else if ($signed(param_data) >= -32'sd524288 &&
			     $signed(param_data) < 32'sd1572864) begin
			size = 3'd3;
			shamt = 6'd14;
		end else if ($signed(param_data) >= -32'sd67108864 &&
			     $signed(param_data) < 32'sd201326592) begin
			size = 3'd4;
			shamt = 6'd7;
		end else begin
			size = 3'd5;
			shamt = 6'd0;
		end
	end

	assign byte_valid = (state == E_ID) || (state == E_EMIT);
	assign send_ring_wr_en = byte_valid && !send_ring_full;
	assign send_ring_data = (state == E_ID) ? id_q : {cnt != 3'd1, sh[34:28]};
	assign last_param = ({1'b0, param_idx} + 4'd1) == {1'b0, np_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= E_IDLE;
			rsp_finished <= 1'b0;
			send_fifo_wr_en <= 1'b0;
		end else begin
			rsp_finished <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			case (state)
				E_IDLE: begin
					if (rsp_start) begin
						id_q <= rsp_id;
						np_q <= nparams;
						param_idx <= '0;
						state <= E_ID;
					end
				end
				E_ID: begin
					if (send_ring_wr_en) begin
						len <= 8'd1;
						if (np_q == 3'd0) begin
							send_fifo_data <= 8'd1;
							send_fifo_wr_en <= 1'b1;
							rsp_finished <= 1'b1;
							state <= E_IDLE;
						end else begin
							state <= E_SIZE;
						end
					end
				end
				E_SIZE: begin
					if (!send_ring_full) begin
						sh <= p_ext << shamt;
						cnt <= size;
						state <= E_EMIT;
					end
				end
				default: begin
					if (send_ring_wr_en) begin
						sh <= {sh[27:0], 7'b0};
						cnt <= cnt - 3'd1;
						len <= len + 8'd1;
						if (cnt == 3'd1) begin
							if (last_param) begin
								send_fifo_data <= len + 8'd1;
								send_fifo_wr_en <= 1'b1;
								rsp_finished <= 1'b1;
								state <= E_IDLE;
							end else begin
								param_idx <= param_idx + 3'd1;
								state <= E_SIZE;
							end
						end
					end
				end
			endcase
		end
	end

	// a blocked byte is offered again unchanged.
	assert property (@(posedge clk) disable iff (rst)
		byte_valid && send_ring_full |=> byte_valid && $stable(send_ring_data));

endmodule
